/* pri_icache.f */
hw/icache_pkg.sv
hw/icache_tag_store.sv
hw/icache_data_bank.sv
hw/icache_ctrl.sv
hw/pri_icache.sv
sim/pri_icache_chk.sv
sim/pri_icache_tb.sv

/* Bender.yml */
package:
  name: pri_icache

dependencies: {}

sources:
  # Synthesizable cache
  - files:
      - hw/icache_pkg.sv
      - hw/icache_tag_store.sv
      - hw/icache_data_bank.sv
      - hw/icache_ctrl.sv
      - hw/pri_icache.sv
  # Simulation only
  - target: simulation
    files:
      - sim/pri_icache_chk.sv
      - sim/pri_icache_tb.sv

/* sim/pri_icache_tb.sv */
/*
 * Testbench of the private instruction cache. Fetches come from an LFSR
 * over a small address window, refills are answered by a memory model,
 * and every returned line is checked against a reference hash and a
 * shadow copy of the tag store.
 */

`timescale 1ns/1ps

module pri_icache_tb;

   import icache_pkg::*;

   localparam int unsigned N_RAND         = 240;              // Fetches in the random window
   localparam int unsigned NUM_FETCHES    = N_RAND + 13;      // Plus the directed ones
   localparam int unsigned TIMEOUT_CYCLES = 40 * NUM_FETCHES + 200;

   localparam logic [TAG_WIDTH-1:0] TAG_BASE = 22'h2A5C0;
   localparam fetch_addr_t ADDR_A = '{tag: TAG_BASE + 22'd1, index: 6'd2, offset: 4'h4};
   localparam fetch_addr_t ADDR_B = '{tag: TAG_BASE + 22'd2, index: 6'd3, offset: 4'hC};

   // One granted fetch waiting for its answer
   typedef struct packed {
      fetch_addr_t addr;     // As granted
      logic        miss;     // Shadow predicts a refill
      logic [31:0] gnt_cyc;  // Cycle that ends in the grant edge
   } exp_t;

   logic        clk;
   logic        rst_i;
   logic        fetch_req_i;
   fetch_addr_t fetch_addr_i;
   logic        fetch_gnt_o;
   logic        fetch_rvalid_o;
   line_t       fetch_rdata_o;
   logic        refill_req_o;
   fetch_addr_t refill_addr_o;
   logic        refill_gnt_i;
   logic        refill_r_valid_i;
   line_t       refill_r_data_i;
   logic        bypass_icache_i;
   logic        cache_is_bypassed_o;
   logic        flush_icache_i;
   logic        cache_is_flushed_o;

   logic [31:0]          lfsr_q   = 32'h0478_9f37;
   int unsigned          cyc      = 0;
   int unsigned          issued   = 0;   // Grants so far
   int unsigned          resp_cnt = 0;   // Answers checked so far
   exp_t                 exp_q [$];      // Scoreboard
   fetch_addr_t          refill_q [$];   // Refill addresses seen by memory
   bit                   bypass_on = 0;
   bit                   sh_valid [NB_WAYS][NB_SETS];
   logic [TAG_WIDTH-1:0] sh_tag [NB_WAYS][NB_SETS];
   int unsigned          sh_rr = 0;      // Shadow of the victim pointer

   pri_icache pri_icache_inst (.*);

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   //////////////////////////////////////////////////////////////////////
   // Random bits, reference data and shadow tag store
   //////////////////////////////////////////////////////////////////////

   function automatic int unsigned take_bits(int unsigned n);
      int unsigned v;
      v = 0;
      for (int i = 0; i < n; i++)
      begin
         lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'hD000_0001) : (lfsr_q >> 1);
         v      = (v << 1) | lfsr_q[0];   // One step per bit
      end
      return v;
   endfunction

   function automatic fetch_addr_t rand_addr();
      fetch_addr_t a;
      a.tag    = TAG_BASE + TAG_WIDTH'(take_bits(3));   // 8 tags per row, forces evictions
      a.index  = INDEX_WIDTH'(take_bits(2));
      a.offset = OFFSET_WIDTH'(take_bits(4));
      return a;
   endfunction

   // Line content is a hash of the whole line address
   function automatic line_t ref_line(fetch_addr_t a);
      line_t       l;
      logic [31:0] la;
      la = {a.tag, a.index, {OFFSET_WIDTH{1'b0}}};
      for (int k = 0; k < 4; k++)
         l[32*k +: 32] = (la ^ (32'h0101_0101 * k)) * 32'h9E37_79B9 + k;
      return l;
   endfunction

   // Returns hit and applies the fill on a miss
   function automatic bit shadow_lookup(fetch_addr_t a);
      int victim;
      victim = -1;
      if (bypass_on)
         return 1'b0;                          // Always refills, store untouched
      for (int w = 0; w < NB_WAYS; w++)
      begin
         if (sh_valid[w][a.index] && sh_tag[w][a.index] == a.tag)
            return 1'b1;
      end
      for (int w = NB_WAYS - 1; w >= 0; w--)
      begin
         if (!sh_valid[w][a.index])
            victim = w;                        // Lowest free way
      end
      if (victim < 0)
      begin
         victim = sh_rr;                       // Eviction moves the pointer
         sh_rr  = (sh_rr + 1) % NB_WAYS;
      end
      sh_valid[victim][a.index] = 1'b1;
      sh_tag[victim][a.index]   = a.tag;
      return 1'b0;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Compare tasks and run control
   //////////////////////////////////////////////////////////////////////

   task automatic abort_run();
      $display("RESULT: FAIL");
      $fatal(1, "Simulation stopped at first error");
   endtask

   task automatic check_line(string name, line_t exp, line_t act);
      if (act !== exp)
      begin
         $display("ERR %0t %s exp=%h act=%h", $time, name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_addr(string name, fetch_addr_t exp, fetch_addr_t act);
      if (act !== exp)
      begin
         $display("ERR %0t %s exp=%h act=%h", $time, name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_bit(string name, logic exp, logic act);
      if (act !== exp)
      begin
         $display("ERR %0t %s exp=%b act=%b", $time, name, exp, act);
         abort_run();
      end
   endtask

   task automatic next_cycle();
      @(posedge clk);
      #1;                                      // Inputs move just after the edge
   endtask

   // Status flags and an idle port, sampled mid-cycle
   task automatic check_status(logic exp_byp, logic exp_flushed);
      @(negedge clk);
      check_bit("fetch_gnt_o", 1'b0, fetch_gnt_o);
      check_bit("fetch_rvalid_o", 1'b0, fetch_rvalid_o);
      check_bit("refill_req_o", 1'b0, refill_req_o);
      check_bit("cache_is_bypassed_o", exp_byp, cache_is_bypassed_o);
      check_bit("cache_is_flushed_o", exp_flushed, cache_is_flushed_o);
      next_cycle();
   endtask

   // Hold the request until granted, then wait for the answer
   task automatic do_fetch(fetch_addr_t a);
      exp_t e;
      e.addr       = a;
      e.miss       = !shadow_lookup(a);
      fetch_req_i  = 1'b1;
      fetch_addr_i = a;
      do
         @(negedge clk);
      while (fetch_gnt_o !== 1'b1);
      e.gnt_cyc = cyc;
      exp_q.push_back(e);
      next_cycle();
      fetch_req_i = 1'b0;
      issued++;
      while (resp_cnt != issued)
         @(posedge clk);
      #1;
   endtask

   always @(posedge clk)
   begin
      cyc <= cyc + 1;
      if (cyc >= TIMEOUT_CYCLES)
      begin
         $display("Timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         abort_run();
      end
      if (pri_icache_inst.pri_icache_chk_inst.fail_cnt != 0)
      begin
         $display("A protocol assertion failed before %0t", $time);
         abort_run();
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Refill memory and response compare
   //////////////////////////////////////////////////////////////////////

   initial
   begin : refill_memory
      fetch_addr_t ra;
      int unsigned d;
      forever
      begin
         @(negedge clk);
         if (refill_req_o === 1'b1 && !rst_i)
         begin
            ra = refill_addr_o;
            refill_q.push_back(ra);
            d = take_bits(2);                  // Grant after 0 to 3 extra cycles
            next_cycle();
            repeat (d) next_cycle();
            refill_gnt_i = 1'b1;
            next_cycle();
            refill_gnt_i = 1'b0;
            d = 1 + take_bits(2);              // Line 1 to 4 cycles after grant
            repeat (d - 1) next_cycle();
            refill_r_valid_i = 1'b1;
            refill_r_data_i  = ref_line(ra);
            next_cycle();
            refill_r_valid_i = 1'b0;
         end
      end
   end

   initial
   begin : compare
      exp_t        e;
      fetch_addr_t line_a;
      forever
      begin
         @(negedge clk);
         if (fetch_rvalid_o === 1'b1)
         begin
            if (exp_q.size() == 0)
            begin
               $display("fetch_rvalid_o high at %0t with no fetch outstanding", $time);
               abort_run();
            end
            e      = exp_q.pop_front();
            line_a = '{tag: e.addr.tag, index: e.addr.index, offset: '0};
            check_line("fetch_rdata_o", ref_line(e.addr), fetch_rdata_o);
            check_bit("refill_req_o", e.miss, refill_q.size() != 0);  // Refill iff miss
            if (e.miss)
               check_addr("refill_addr_o", line_a, refill_q.pop_front());
            else if (cyc != e.gnt_cyc + 1)
            begin
               $display("Hit on %h answered %0d cycles after its grant",
                        e.addr, cyc - e.gnt_cyc);
               abort_run();
            end
            resp_cnt++;
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Test sequence
   //////////////////////////////////////////////////////////////////////

   initial
   begin : stimulus
      rst_i            = 1'b1;
      fetch_req_i      = 1'b0;
      fetch_addr_i     = '0;
      refill_gnt_i     = 1'b0;
      refill_r_valid_i = 1'b0;
      refill_r_data_i  = '0;
      bypass_icache_i  = 1'b0;
      flush_icache_i   = 1'b0;
      repeat (16) @(posedge clk);
      #1;
      rst_i = 1'b0;
      check_status(1'b0, 1'b1);                // Flushed out of reset

      // First fetch refills, repeat hits
      do_fetch(ADDR_A);
      check_status(1'b0, 1'b0);
      do_fetch(ADDR_A);

      for (int i = 0; i < N_RAND; i++)
         do_fetch(rand_addr());

      // Bypass, A stays cached underneath
      do_fetch(ADDR_A);
      bypass_icache_i = 1'b1;
      bypass_on       = 1'b1;
      next_cycle();
      check_status(1'b1, 1'b0);
      do_fetch(ADDR_A);                        // Cached line still refills
      repeat (3) do_fetch(rand_addr());
      bypass_icache_i = 1'b0;
      bypass_on       = 1'b0;
      next_cycle();
      check_status(1'b0, 1'b0);
      do_fetch(ADDR_A);                        // Hit again

      // Whole cache flush
      do_fetch(ADDR_B);
      do_fetch(ADDR_A);
      flush_icache_i = 1'b1;
      next_cycle();
      flush_icache_i = 1'b0;
      foreach (sh_valid[w, s])
         sh_valid[w][s] = 1'b0;
      check_status(1'b0, 1'b1);
      do_fetch(ADDR_A);                        // Misses once
      check_status(1'b0, 1'b0);
      do_fetch(ADDR_A);
      do_fetch(ADDR_B);

      repeat (4) next_cycle();
      if (pri_icache_inst.pri_icache_chk_inst.fail_cnt != 0)
      begin
         $display("Protocol assertions failed during the run");
         abort_run();
      end
      else
      begin
         $display("RESULT: PASS");
         $finish;
      end
   end

endmodule

/* sim/pri_icache_chk.sv */
/*
 * Protocol assertions on the cache ports, bound into the top level.
 * Failures count up in fail_cnt for the testbench to pick up.
 */

`timescale 1ns/1ps

module pri_icache_chk (
   input logic                    clk,
   input logic                    rst_i,
   input logic                    fetch_gnt_i,
   input logic                    fetch_rvalid_i,
   input logic                    refill_req_i,
   input icache_pkg::fetch_addr_t refill_addr_i,
   input logic                    refill_gnt_i,
   input logic                    tag_flush_i      // Internal flush strobe
);

   int unsigned fail_cnt = 0;
   int          outstanding_q;   // Grants not yet answered

   always_ff @(posedge clk)
   begin
      if (rst_i)
         outstanding_q <= 0;
      else
         outstanding_q <= outstanding_q + int'(fetch_gnt_i) - int'(fetch_rvalid_i);
   end

   // Refill request held with a stable address until granted
   refill_hold_a: assert property (@(posedge clk) disable iff (rst_i)
      refill_req_i && !refill_gnt_i |=> refill_req_i && $stable(refill_addr_i))
      else
      begin
         $error("refill request dropped or address changed before grant");
         fail_cnt = fail_cnt + 1;
      end

   rvalid_owed_a: assert property (@(posedge clk) disable iff (rst_i)
      fetch_rvalid_i |-> outstanding_q > 0)
      else
      begin
         $error("fetch rvalid without an outstanding grant");
         fail_cnt = fail_cnt + 1;
      end

   flush_quiet_a: assert property (@(posedge clk) disable iff (rst_i)
      tag_flush_i |=> !refill_req_i)
      else
      begin
         $error("refill requested right after a flush");
         fail_cnt = fail_cnt + 1;
      end

endmodule

bind pri_icache pri_icache_chk pri_icache_chk_inst (
   .clk            ( clk              ),
   .rst_i          ( rst_i            ),
   .fetch_gnt_i    ( fetch_gnt_o      ),
   .fetch_rvalid_i ( fetch_rvalid_o   ),
   .refill_req_i   ( refill_req_o     ),
   .refill_addr_i  ( refill_addr_o    ),
   .refill_gnt_i   ( refill_gnt_i     ),
   .tag_flush_i    ( tag_flush        )
);

/* hw/pri_icache.sv */
/*
 * Private four-way instruction cache of one core. Fetch requests use
 * req/gnt/rvalid, misses refill one line over a single refill port.
 */

`timescale 1ns/1ps

module pri_icache (
   input  logic                    clk,
   input  logic                    rst_i,

   // Core side
   input  logic                    fetch_req_i,
   input  icache_pkg::fetch_addr_t fetch_addr_i,
   output logic                    fetch_gnt_o,
   output logic                    fetch_rvalid_o,
   output icache_pkg::line_t       fetch_rdata_o,

   // Memory side
   output logic                    refill_req_o,
   output icache_pkg::fetch_addr_t refill_addr_o,
   input  logic                    refill_gnt_i,
   input  logic                    refill_r_valid_i,
   input  icache_pkg::line_t       refill_r_data_i,

   input  logic                    bypass_icache_i,
   output logic                    cache_is_bypassed_o,
   input  logic                    flush_icache_i,
   output logic                    cache_is_flushed_o
);

   import icache_pkg::*;

   logic                     tag_rd_en;
   logic [INDEX_WIDTH-1:0]   tag_index;    // Tag and data row
   tag_entry_t [NB_WAYS-1:0] tag_entries;
   way_sel_t                 tag_wr_way;
   tag_entry_t               tag_wr_entry;
   logic                     tag_flush;
   way_sel_t                 data_rd_en;
   way_sel_t                 data_wr_en;
   line_t [NB_WAYS-1:0]      data_rdata;

   icache_ctrl i_icache_ctrl (
      .clk                 ( clk                 ),
      .rst_i               ( rst_i               ),
      .fetch_req_i         ( fetch_req_i         ),
      .fetch_addr_i        ( fetch_addr_i        ),
      .fetch_gnt_o         ( fetch_gnt_o         ),
      .fetch_rvalid_o      ( fetch_rvalid_o      ),
      .fetch_rdata_o       ( fetch_rdata_o       ),
      .refill_req_o        ( refill_req_o        ),
      .refill_addr_o       ( refill_addr_o       ),
      .refill_gnt_i        ( refill_gnt_i        ),
      .refill_r_valid_i    ( refill_r_valid_i    ),
      .refill_r_data_i     ( refill_r_data_i     ),
      .bypass_icache_i     ( bypass_icache_i     ),
      .cache_is_bypassed_o ( cache_is_bypassed_o ),
      .flush_icache_i      ( flush_icache_i      ),
      .cache_is_flushed_o  ( cache_is_flushed_o  ),
      .tag_rd_en_o         ( tag_rd_en           ),
      .tag_index_o         ( tag_index           ),
      .tag_entries_i       ( tag_entries         ),
      .tag_wr_way_o        ( tag_wr_way          ),
      .tag_wr_entry_o      ( tag_wr_entry        ),
      .tag_flush_o         ( tag_flush           ),
      .data_rd_en_o        ( data_rd_en          ),
      .data_wr_en_o        ( data_wr_en          ),
      .data_rdata_i        ( data_rdata          )
   );

   icache_tag_store i_icache_tag_store (
      .clk          ( clk          ),
      .rst_i        ( rst_i        ),
      .rd_en_i      ( tag_rd_en    ),
      .rd_index_i   ( tag_index    ),
      .rd_entries_o ( tag_entries  ),
      .wr_way_i     ( tag_wr_way   ),
      .wr_index_i   ( tag_index    ),  // Never read in a write cycle
      .wr_entry_i   ( tag_wr_entry ),
      .flush_all_i  ( tag_flush    )
   );

   // One bank per way, refill data written straight from the port
   for (genvar w = 0; w < NB_WAYS; w++)
   begin : gen_data_way
      icache_data_bank i_icache_data_bank (
         .clk     ( clk             ),
         .rd_en_i ( data_rd_en[w]   ),
         .wr_en_i ( data_wr_en[w]   ),
         .index_i ( tag_index       ),
         .wdata_i ( refill_r_data_i ),
         .rdata_o ( data_rdata[w]   )
      );
   end

endmodule

/* hw/icache_ctrl.sv */
/*
 * Cache controller. Grants fetches, compares tags one cycle later,
 * answers hits directly and runs one refill per miss. Also owns the
 * victim choice, the bypass status and the whole-cache flush.
 */

`timescale 1ns/1ps

module icache_ctrl (
   input  logic                                        clk,
   input  logic                                        rst_i,

   // Core fetch port
   input  logic                                        fetch_req_i,
   input  icache_pkg::fetch_addr_t                     fetch_addr_i,
   output logic                                        fetch_gnt_o,
   output logic                                        fetch_rvalid_o,
   output icache_pkg::line_t                           fetch_rdata_o,

   // Refill port
   output logic                                        refill_req_o,
   output icache_pkg::fetch_addr_t                     refill_addr_o,
   input  logic                                        refill_gnt_i,
   input  logic                                        refill_r_valid_i,
   input  icache_pkg::line_t                           refill_r_data_i,

   // Control and status
   input  logic                                        bypass_icache_i,
   output logic                                        cache_is_bypassed_o,
   input  logic                                        flush_icache_i,
   output logic                                        cache_is_flushed_o,

   // Tag store
   output logic                                        tag_rd_en_o,
   output logic [icache_pkg::INDEX_WIDTH-1:0]          tag_index_o,   // Also data index
   input  icache_pkg::tag_entry_t [icache_pkg::NB_WAYS-1:0] tag_entries_i,
   output icache_pkg::way_sel_t                        tag_wr_way_o,
   output icache_pkg::tag_entry_t                      tag_wr_entry_o,
   output logic                                        tag_flush_o,

   // Data banks
   output icache_pkg::way_sel_t                        data_rd_en_o,
   output icache_pkg::way_sel_t                        data_wr_en_o,
   input  icache_pkg::line_t [icache_pkg::NB_WAYS-1:0] data_rdata_i
);

   import icache_pkg::*;

   ctrl_state_e state_q, state_d;
   fetch_addr_t addr_q;          // Granted request
   line_t       rdata_q;         // Refilled line for REPLY
   logic        byp_req_q;       // Granted request bypasses the store
   logic        flush_pend_q;    // Flush seen outside IDLE
   logic        bypass_q;
   logic        flushed_q;
   way_idx_t    rr_q;            // Round-robin victim pointer
   way_idx_t    victim_q, victim_d;
   logic        victim_valid_q;  // Victim holds a valid line
   logic        all_valid;

   way_sel_t    hit_way;
   logic        hit;
   line_t       hit_line;
   logic        flush_now;
   logic        refill_wr;

   //////////////////////////////////////////////////////////////////////
   // Lookup and victim choice
   //////////////////////////////////////////////////////////////////////

   always_comb
   begin
      hit_line = '0;
      for (int w = 0; w < NB_WAYS; w++)
      begin
         hit_way[w] = tag_entries_i[w].valid && (tag_entries_i[w].tag == addr_q.tag);
         if (hit_way[w])
            hit_line = hit_line | data_rdata_i[w];  // At most one way hits
      end
   end

   assign hit = (state_q == LOOKUP) && (|hit_way);

   // Lowest invalid way first, else the round-robin pointer
   always_comb
   begin
      victim_d  = rr_q;
      all_valid = 1'b1;
      for (int w = NB_WAYS - 1; w >= 0; w--)
      begin
         if (!tag_entries_i[w].valid)
         begin
            victim_d  = way_idx_t'(w);
            all_valid = 1'b0;
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Handshakes and store control
   //////////////////////////////////////////////////////////////////////

   assign flush_now = (state_q == IDLE) && (flush_icache_i || flush_pend_q);

   always_comb
   begin
      case (state_q)
         IDLE:    fetch_gnt_o = fetch_req_i && !flush_now;
         LOOKUP:  fetch_gnt_o = fetch_req_i && hit && !bypass_icache_i
                                && !flush_icache_i && !flush_pend_q;  // Back-to-back hit
         default: fetch_gnt_o = 1'b0;                                 // Miss holds off the core
      endcase
   end

   assign fetch_rvalid_o = hit || (state_q == REPLY);
   assign fetch_rdata_o  = (state_q == REPLY) ? rdata_q : hit_line;

   assign refill_req_o   = (state_q == REFILL_REQ);
   assign refill_addr_o  = '{tag: addr_q.tag, index: addr_q.index, offset: '0};  // Line address

   assign tag_rd_en_o    = fetch_gnt_o && !bypass_icache_i;
   assign tag_index_o    = fetch_gnt_o ? fetch_addr_i.index : addr_q.index;
   assign data_rd_en_o   = {NB_WAYS{tag_rd_en_o}};  // Way unknown before compare

   // Store write on refill, skipped in bypass
   assign refill_wr      = (state_q == REFILL_WAIT) && refill_r_valid_i && !byp_req_q;
   assign tag_wr_way_o   = refill_wr ? (way_sel_t'(1) << victim_q) : '0;
   assign data_wr_en_o   = tag_wr_way_o;
   assign tag_wr_entry_o = '{valid: 1'b1, tag: addr_q.tag};
   assign tag_flush_o    = flush_now;

   assign cache_is_bypassed_o = bypass_q;
   assign cache_is_flushed_o  = flushed_q;

   //////////////////////////////////////////////////////////////////////
   // FSM
   //////////////////////////////////////////////////////////////////////

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         IDLE:
            if (fetch_gnt_o)
               state_d = bypass_icache_i ? REFILL_REQ : LOOKUP;
         LOOKUP:
            if (!hit)
               state_d = REFILL_REQ;
            else if (!fetch_gnt_o)
               state_d = IDLE;           // Stay on a new grant
         REFILL_REQ:
            if (refill_gnt_i)
               state_d = REFILL_WAIT;
         REFILL_WAIT:
            if (refill_r_valid_i)
               state_d = REPLY;
         default:
            state_d = IDLE;              // REPLY lasts one cycle
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (rst_i)
      begin
         state_q      <= IDLE;
         byp_req_q    <= 1'b0;
         flush_pend_q <= 1'b0;
         bypass_q     <= 1'b0;
         flushed_q    <= 1'b1;           // Valid bits cleared by reset
         rr_q         <= '0;
      end
      else
      begin
         state_q <= state_d;
         if (fetch_gnt_o)
            byp_req_q <= bypass_icache_i;
         if (flush_now)
            flush_pend_q <= 1'b0;
         else if (flush_icache_i)
            flush_pend_q <= 1'b1;        // Wait for IDLE
         if (state_q == IDLE)
            bypass_q <= bypass_icache_i;
         else if (!bypass_icache_i)
            bypass_q <= 1'b0;
         if (flush_now)
            flushed_q <= 1'b1;
         else if (refill_wr)
            flushed_q <= 1'b0;
         if (refill_wr && victim_valid_q)
            rr_q <= rr_q + 1'b1;         // Only on eviction
      end
   end

   // Request and refill payload
   always_ff @(posedge clk)
   begin
      if (fetch_gnt_o)
         addr_q <= fetch_addr_i;
      if ((state_q == LOOKUP) && !hit)
      begin
         victim_q       <= victim_d;
         victim_valid_q <= all_valid;
      end
      if ((state_q == REFILL_WAIT) && refill_r_valid_i)
         rdata_q <= refill_r_data_i;
   end

endmodule

/* hw/icache_data_bank.sv */
/*
 * Line storage of one way. NB_SETS lines deep, one write or read per
 * row access, read data registered and held until the next read.
 */

`timescale 1ns/1ps

module icache_data_bank (
   input  logic                               clk,
   input  logic                               rd_en_i,   // Read strobe
   input  logic                               wr_en_i,   // Refill write strobe
   input  logic [icache_pkg::INDEX_WIDTH-1:0] index_i,   // Shared row address
   input  icache_pkg::line_t                  wdata_i,
   output icache_pkg::line_t                  rdata_o
);

   import icache_pkg::*;

   line_t mem [NB_SETS];  // Storage rows
   line_t rdata_q;        // Read register

   always_ff @(posedge clk)
   begin
      if (wr_en_i)
         mem[index_i] <= wdata_i;
      if (rd_en_i)
         rdata_q <= mem[index_i];   // Valid the cycle after the strobe
   end

   assign rdata_o = rdata_q;

endmodule

/* hw/icache_tag_store.sv */
/*
 * Valid bits and tags of all ways. One registered read of every way per
 * cycle, one write port with a one-hot way select, and a flush that
 * clears every valid bit in a single cycle.
 */

`timescale 1ns/1ps

module icache_tag_store (
   input  logic                                        clk,
   input  logic                                        rst_i,

   // Read port, all ways at once
   input  logic                                        rd_en_i,
   input  logic [icache_pkg::INDEX_WIDTH-1:0]          rd_index_i,
   output icache_pkg::tag_entry_t [icache_pkg::NB_WAYS-1:0] rd_entries_o,

   // Write port
   input  icache_pkg::way_sel_t                        wr_way_i,
   input  logic [icache_pkg::INDEX_WIDTH-1:0]          wr_index_i,
   input  icache_pkg::tag_entry_t                      wr_entry_i,

   input  logic                                        flush_all_i
);

   import icache_pkg::*;

   logic [NB_WAYS-1:0][NB_SETS-1:0] valid_q;                // Flops, so flush is one cycle
   logic [TAG_WIDTH-1:0]            tag_mem [NB_WAYS][NB_SETS];
   tag_entry_t [NB_WAYS-1:0]        rd_entries_q;

   // Valid bits
   always_ff @(posedge clk)
   begin
      if (rst_i || flush_all_i)
         valid_q <= '0;                                     // Whole cache invalid
      else
      begin
         for (int w = 0; w < NB_WAYS; w++)
         begin
            if (wr_way_i[w])
               valid_q[w][wr_index_i] <= wr_entry_i.valid;
         end
      end
   end

   // Tag array and registered read
   always_ff @(posedge clk)
   begin
      for (int w = 0; w < NB_WAYS; w++)
      begin
         if (wr_way_i[w])
            tag_mem[w][wr_index_i] <= wr_entry_i.tag;
         if (rd_en_i)
            rd_entries_q[w] <= '{valid: valid_q[w][rd_index_i],
                                 tag:   tag_mem[w][rd_index_i]};  // No write forwarding
      end
   end

   assign rd_entries_o = rd_entries_q;

endmodule

/* hw/icache_pkg.sv */
/*
 * Shared geometry, address layout and FSM encoding of the private
 * instruction cache. Every cache module imports this package.
 */

package icache_pkg;

   //////////////////////////////////////////////////////////////////////
   // Geometry
   //////////////////////////////////////////////////////////////////////

   localparam int unsigned FETCH_ADDR_WIDTH = 32;    // Core fetch address
   localparam int unsigned FETCH_DATA_WIDTH = 128;   // One fetch word is one line
   localparam int unsigned NB_WAYS          = 4;     // Associativity
   localparam int unsigned CACHE_SIZE       = 4096;  // Capacity in bytes

   // Byte offset inside one line
   localparam int unsigned OFFSET_WIDTH = $clog2(FETCH_DATA_WIDTH / 8);

   // Rows per way
   localparam int unsigned NB_SETS     = CACHE_SIZE / (NB_WAYS * (FETCH_DATA_WIDTH / 8));
   localparam int unsigned INDEX_WIDTH = $clog2(NB_SETS);

   // Full tag, no reduced-tag trick
   localparam int unsigned TAG_WIDTH = FETCH_ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;

   //////////////////////////////////////////////////////////////////////
   // Types
   //////////////////////////////////////////////////////////////////////

   // Fetch address split into its cache fields
   typedef struct packed {
      logic [TAG_WIDTH-1:0]    tag;     // Upper bits, compared on lookup
      logic [INDEX_WIDTH-1:0]  index;   // Row select
      logic [OFFSET_WIDTH-1:0] offset;  // Byte in line, unused by the store
   } fetch_addr_t;

   // One entry of the tag store
   typedef struct packed {
      logic                 valid;
      logic [TAG_WIDTH-1:0] tag;
   } tag_entry_t;

   typedef logic [FETCH_DATA_WIDTH-1:0] line_t;     // Line payload
   typedef logic [NB_WAYS-1:0]          way_sel_t;  // One-hot way vector
   typedef logic [$clog2(NB_WAYS)-1:0]  way_idx_t;  // Way number

   // Controller states
   typedef enum logic [2:0] {
      IDLE,         // Waiting for a fetch, flush taken here
      LOOKUP,       // Tags and lines valid, compare
      REFILL_REQ,   // Refill request held until granted
      REFILL_WAIT,  // Waiting for the refill line
      REPLY         // Return the refilled line to the core
   } ctrl_state_e;

endpackage
